/* design/videoPkg.sv */
// Video pixel generator shared widths, dot and pixel types and register map
package videoPkg;

	// ------------------------------
	// Colour widths
	// ------------------------------
	// Full dot with alpha on top
	localparam int cColorDepth = 16;
	localparam int cAlphaWidth = 4;
	// Colour bits left once alpha is stripped
	localparam int cOutDepth = cColorDepth - cAlphaWidth;
	// Background and player
	localparam int cLayers = 2;

	// Layer dot as queued by a draw layer
	typedef struct packed {
		logic [cAlphaWidth-1:0] alpha;
		logic [cOutDepth-1:0] rgb;
	} dotT;

	// Final pixel for the video sink
	typedef logic [cOutDepth-1:0] pixelT;

	// ------------------------------
	// Configuration register map
	// ------------------------------
	typedef enum logic [3:0] {
		cfgHdisp,
		cfgVdisp,
		cfgRun,
		// Background layer rectangle and colour
		cfgL0X0,
		cfgL0X1,
		cfgL0Y0,
		cfgL0Y1,
		cfgL0Color,
		// Player layer rectangle and colour
		cfgL1X0,
		cfgL1X1,
		cfgL1Y0,
		cfgL1Y1,
		cfgL1Color
	} cfgAddrT;

endpackage

/* design/videoIfs.sv */
// Raster position and layer rectangle configuration interfaces of the pixel generator
`timescale 1ns/1ps

// Scan position from the counter to the draw layers
interface rasterIf #(
	parameter int pHdisplayWidth = 11,
	parameter int pVdisplayWidth = 11
);
	logic [pHdisplayWidth-1:0] hPos;
	logic [pVdisplayWidth-1:0] vPos;
	// Last visible position of the frame
	logic frameEnd;
	// Position consumed this cycle
	logic advance;

	modport src (output hPos, output vPos, output frameEnd, input advance);
	modport sink (input hPos, input vPos, input frameEnd, input advance);
endinterface

// Rectangle bounds and colour of one draw layer
interface layerCfgIf #(
	parameter int pHdisplayWidth = 11,
	parameter int pVdisplayWidth = 11
);
	import videoPkg::*;
	logic [pHdisplayWidth-1:0] x0;
	logic [pHdisplayWidth-1:0] x1;
	logic [pVdisplayWidth-1:0] y0;
	logic [pVdisplayWidth-1:0] y1;
	dotT color;

	modport src (output x0, output x1, output y0, output y1, output color);
	modport sink (input x0, input x1, input y0, input y1, input color);
endinterface

/* design/displayCfg.sv */
// Configuration registers for display size, run bit and layer rectangles
`timescale 1ns/1ps

module displayCfg #(
	parameter int pHdisplayWidth = 11,
	parameter int pVdisplayWidth = 11
)(
	input  logic iClk,
	input  logic arstN,
	input  logic cfgWe,
	input  videoPkg::cfgAddrT cfgAddr,
	input  logic [15:0] cfgData,
	output logic [pHdisplayWidth-1:0] hLast,
	output logic [pVdisplayWidth-1:0] vLast,
	output logic run,
	layerCfgIf.src layerCfg [videoPkg::cLayers]
);
	import videoPkg::*;

	// Per layer rectangle and colour
	logic [pHdisplayWidth-1:0] x0Q [cLayers];
	logic [pHdisplayWidth-1:0] x1Q [cLayers];
	logic [pVdisplayWidth-1:0] y0Q [cLayers];
	logic [pVdisplayWidth-1:0] y1Q [cLayers];
	dotT colorQ [cLayers];

	// ------------------------------
	// Register write decode
	// ------------------------------
	always_ff @(posedge iClk or negedge arstN)
	begin
		if (!arstN)
		begin
			hLast <= '0;
			vLast <= '0;
			run <= 1'b0;
			for (int i = 0; i < cLayers; i++)
			begin
				x0Q[i] <= '0;
				x1Q[i] <= '0;
				y0Q[i] <= '0;
				y1Q[i] <= '0;
				colorQ[i] <= '0;
			end
		end
		else if (cfgWe)
		begin
			case (cfgAddr)
				// Size kept as last index, so 480 wide counts 0 to 479
				cfgHdisp: hLast <= cfgData[pHdisplayWidth-1:0] - 1'b1;
				cfgVdisp: vLast <= cfgData[pVdisplayWidth-1:0] - 1'b1;
				cfgRun: run <= cfgData[0];
				// Background layer
				cfgL0X0: x0Q[0] <= cfgData[pHdisplayWidth-1:0];
				cfgL0X1: x1Q[0] <= cfgData[pHdisplayWidth-1:0];
				cfgL0Y0: y0Q[0] <= cfgData[pVdisplayWidth-1:0];
				cfgL0Y1: y1Q[0] <= cfgData[pVdisplayWidth-1:0];
				cfgL0Color: colorQ[0] <= dotT'(cfgData);
				// Player layer
				cfgL1X0: x0Q[1] <= cfgData[pHdisplayWidth-1:0];
				cfgL1X1: x1Q[1] <= cfgData[pHdisplayWidth-1:0];
				cfgL1Y0: y0Q[1] <= cfgData[pVdisplayWidth-1:0];
				cfgL1Y1: y1Q[1] <= cfgData[pVdisplayWidth-1:0];
				cfgL1Color: colorQ[1] <= dotT'(cfgData);
				default: ;
			endcase
		end
	end

	// Drive each layer's bundle
	for (genvar gi = 0; gi < cLayers; gi++)
	begin : gLayerOut
		assign layerCfg[gi].x0 = x0Q[gi];
		assign layerCfg[gi].x1 = x1Q[gi];
		assign layerCfg[gi].y0 = y0Q[gi];
		assign layerCfg[gi].y1 = y1Q[gi];
		assign layerCfg[gi].color = colorQ[gi];
	end

endmodule

/* design/drawPosition.sv */
// Raster position counter walking the visible area in scan order
`timescale 1ns/1ps

module drawPosition #(
	parameter int pHdisplayWidth = 11,
	parameter int pVdisplayWidth = 11
)(
	input  logic iClk,
	input  logic arstN,
	input  logic [pHdisplayWidth-1:0] hLast,
	input  logic [pVdisplayWidth-1:0] vLast,
	rasterIf.src ras
);

	logic hEnd;
	logic vEnd;

	// End of line and end of frame
	// Compare with >= so a shrunk frame size still wraps
	assign hEnd = (ras.hPos >= hLast);
	assign vEnd = (ras.vPos >= vLast);

	// High on the final visible position
	assign ras.frameEnd = hEnd && vEnd;

	// ------------------------------
	// Horizontal and vertical step
	// ------------------------------
	always_ff @(posedge iClk or negedge arstN)
	begin
		if (!arstN)
		begin
			ras.hPos <= '0;
			ras.vPos <= '0;
		end
		else if (ras.advance)
		begin
			if (hEnd)
			begin
				// New line, or back to the top
				ras.hPos <= '0;
				if (vEnd)
					ras.vPos <= '0;
				else
					ras.vPos <= ras.vPos + 1'b1;
			end
			else
			begin
				ras.hPos <= ras.hPos + 1'b1;
			end
		end
	end

endmodule

/* design/pixelFifo.sv */
// Synchronous FIFO with registered read data and occupancy based full and empty
`timescale 1ns/1ps

module pixelFifo #(
	parameter type pItem = logic [7:0],
	parameter int pFifoDepth = 16
)(
	input  logic iClk,
	input  logic arstN,
	input  logic wr,
	input  pItem wData,
	output logic full,
	input  logic rd,
	output pItem rData,
	output logic empty
);

	localparam int cAw = (pFifoDepth > 1) ? $clog2(pFifoDepth) : 1;
	localparam int cCw = $clog2(pFifoDepth + 1);

	pItem mem [pFifoDepth];
	logic [cAw-1:0] wPtr;
	logic [cAw-1:0] rPtr;
	logic [cCw-1:0] count;
	logic doWr;
	logic doRd;

	// Pointer step with wrap at any depth
	function automatic logic [cAw-1:0] nextPtr(input logic [cAw-1:0] ptr);
		if (ptr == cAw'(pFifoDepth - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	// Strobes only act when legal
	assign doWr = wr && !full;
	assign doRd = rd && !empty;

	// Levels from occupancy
	assign full = (count == cCw'(pFifoDepth));
	assign empty = (count == '0);

	// ------------------------------
	// Storage and registered read
	// ------------------------------
	always_ff @(posedge iClk)
	begin
		if (doWr)
			mem[wPtr] <= wData;
		// Valid the cycle after the read strobe
		if (doRd)
			rData <= mem[rPtr];
	end

	// Pointers and occupancy
	always_ff @(posedge iClk or negedge arstN)
	begin
		if (!arstN)
		begin
			wPtr <= '0;
			rPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doWr)
				wPtr <= nextPtr(wPtr);
			if (doRd)
				rPtr <= nextPtr(rPtr);
			// Simultaneous read and write leaves count alone
			case ({doWr, doRd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* design/rectLayer.sv */
// Rectangle draw layer turning each raster position into a queued dot
`timescale 1ns/1ps

module rectLayer #(
	parameter int pHdisplayWidth = 11,
	parameter int pVdisplayWidth = 11,
	parameter int pFifoDepth = 16
)(
	input  logic iClk,
	input  logic arstN,
	rasterIf.sink ras,
	layerCfgIf.sink layerCfg,
	output logic full,
	input  logic rd,
	output videoPkg::dotT dot,
	output logic empty
);
	import videoPkg::*;

	logic inH;
	logic inV;
	logic inRect;
	dotT newDot;

	// ------------------------------
	// Rectangle hit test
	// ------------------------------
	// Bounds are inclusive on both ends
	assign inH = (ras.hPos >= layerCfg.x0) && (ras.hPos <= layerCfg.x1);
	assign inV = (ras.vPos >= layerCfg.y0) && (ras.vPos <= layerCfg.y1);
	assign inRect = inH && inV;

	// Configured colour inside, transparent outside
	// Alpha travels with the colour
	assign newDot = inRect ? layerCfg.color : dotT'('0);

	// ------------------------------
	// Dot queue
	// ------------------------------
	// One dot per consumed position
	// Advance is never high while this queue is full
	pixelFifo #(
		.pItem      (dotT),
		.pFifoDepth (pFifoDepth)
	) dotFifo (
		.iClk  (iClk),
		.arstN (arstN),
		.wr    (ras.advance),
		.wData (newDot),
		.full  (full),
		.rd    (rd),
		.rData (dot),
		.empty (empty)
	);

endmodule

/* design/dotMerge.sv */
// Priority compositor popping all layers together and queueing output pixels
`timescale 1ns/1ps

module dotMerge #(
	parameter int pFifoDepth = 16
)(
	input  logic iClk,
	input  logic arstN,
	input  videoPkg::dotT dots [videoPkg::cLayers],
	input  logic [videoPkg::cLayers-1:0] empties,
	output logic rd,
	input  logic iCke,
	output videoPkg::pixelT oPixel,
	output logic oVd
);
	import videoPkg::*;

	// Pop issued last cycle, dots valid now
	logic popQ;
	pixelT mergedPix;
	logic outFull;
	logic outEmpty;
	logic outRd;

	// ------------------------------
	// Layer pop
	// ------------------------------
	// Every layer holds a dot and the output has room
	// Only one pop in flight, keeps a free slot for the late write
	assign rd = !(|empties) && !outFull && !popQ;

	always_ff @(posedge iClk or negedge arstN)
	begin
		if (!arstN)
			popQ <= 1'b0;
		else
			popQ <= rd;
	end

	// ------------------------------
	// Priority composite
	// ------------------------------
	// Higher layer index sits on top
	// Nonzero alpha counts as opaque
	always_comb
	begin
		mergedPix = '0;
		for (int i = 0; i < cLayers; i++)
		begin
			if (dots[i].alpha != '0)
				mergedPix = dots[i].rgb;
		end
	end

	// Alpha already stripped here
	pixelFifo #(
		.pItem      (pixelT),
		.pFifoDepth (pFifoDepth)
	) outFifo (
		.iClk  (iClk),
		.arstN (arstN),
		.wr    (popQ),
		.wData (mergedPix),
		.full  (outFull),
		.rd    (outRd),
		.rData (oPixel),
		.empty (outEmpty)
	);

	// ------------------------------
	// Sink drain
	// ------------------------------
	assign outRd = iCke && !outEmpty;

	// Read data lands one cycle after the strobe
	always_ff @(posedge iClk or negedge arstN)
	begin
		if (!arstN)
			oVd <= 1'b0;
		else
			oVd <= outRd;
	end

endmodule

/* design/videoPixelGen.sv */
// Raster pixel generator top with config, position counter, two layers and merge
`timescale 1ns/1ps

module videoPixelGen #(
	parameter int pHdisplayWidth = 11,
	parameter int pVdisplayWidth = 11,
	parameter int pFifoDepth = 16
)(
	input  logic iClk,
	input  logic arstN,
	input  logic cfgWe,
	input  videoPkg::cfgAddrT cfgAddr,
	input  logic [15:0] cfgData,
	input  logic iCke,
	output videoPkg::pixelT oPixel,
	output logic oVd
);
	import videoPkg::*;

	logic [pHdisplayWidth-1:0] hLast;
	logic [pVdisplayWidth-1:0] vLast;
	logic run;
	logic [cLayers-1:0] layerFull;
	logic [cLayers-1:0] layerEmpty;
	dotT layerDot [cLayers];
	// Common pop to all layers
	logic popRd;

	rasterIf #(.pHdisplayWidth(pHdisplayWidth), .pVdisplayWidth(pVdisplayWidth)) ras ();
	layerCfgIf #(
		.pHdisplayWidth (pHdisplayWidth),
		.pVdisplayWidth (pVdisplayWidth)
	) layerCfg [cLayers] ();

	// Step only while running and every layer queue has room
	assign ras.advance = run && !(|layerFull);

	// ------------------------------
	// Config and raster
	// ------------------------------
	displayCfg #(.pHdisplayWidth(pHdisplayWidth), .pVdisplayWidth(pVdisplayWidth)) uCfg (
		.iClk     (iClk),
		.arstN    (arstN),
		.cfgWe    (cfgWe),
		.cfgAddr  (cfgAddr),
		.cfgData  (cfgData),
		.hLast    (hLast),
		.vLast    (vLast),
		.run      (run),
		.layerCfg (layerCfg)
	);

	drawPosition #(.pHdisplayWidth(pHdisplayWidth), .pVdisplayWidth(pVdisplayWidth)) uPos (
		.iClk  (iClk),
		.arstN (arstN),
		.hLast (hLast),
		.vLast (vLast),
		.ras   (ras)
	);

	// Layer 0 background, layer 1 player
	for (genvar gi = 0; gi < cLayers; gi++)
	begin : gLayer
		rectLayer #(
			.pHdisplayWidth (pHdisplayWidth),
			.pVdisplayWidth (pVdisplayWidth),
			.pFifoDepth     (pFifoDepth)
		) uLayer (
			.iClk     (iClk),
			.arstN    (arstN),
			.ras      (ras),
			.layerCfg (layerCfg[gi]),
			.full     (layerFull[gi]),
			.rd       (popRd),
			.dot      (layerDot[gi]),
			.empty    (layerEmpty[gi])
		);
	end

	// Composite and output queue
	dotMerge #(.pFifoDepth(pFifoDepth)) uMerge (
		.iClk    (iClk),
		.arstN   (arstN),
		.dots    (layerDot),
		.empties (layerEmpty),
		.rd      (popRd),
		.iCke    (iCke),
		.oPixel  (oPixel),
		.oVd     (oVd)
	);

endmodule

/* verif/videoPixelGen_sva.sv */
// Bound assertions on FIFO strobes, FIFO reset state and raster position range
`timescale 1ns/1ps

module videoPixelGenSva #(
	parameter int pPosWidth = 11,
	parameter int pVposWidth = 11,
	// FIFO checks when set, raster checks when clear
	parameter bit pFifoSide = 1'b1
)(
	input logic iClk,
	input logic arstN,
	// FIFO side
	input logic wr,
	input logic rd,
	input logic full,
	input logic empty,
	// Raster side
	input logic stepEn,
	input logic frameEnd,
	input logic [pPosWidth-1:0] pos,
	input logic [pVposWidth-1:0] vPos,
	input logic [pPosWidth-1:0] last
);

	// Sticky flag, set by any failing assertion of this instance
	logic assertFailed;

	initial
		assertFailed = 1'b0;

	if (pFifoSide)
	begin : gFifo
		// ------------------------------
		// FIFO strobes
		// ------------------------------
		aNoWriteFull: assert property (@(posedge iClk) disable iff (!arstN) !(wr && full))
			else
			begin
				$error("write strobe while FIFO full");
				assertFailed = 1'b1;
			end

		aNoReadEmpty: assert property (@(posedge iClk) disable iff (!arstN) !(rd && empty))
			else
			begin
				$error("read strobe while FIFO empty");
				assertFailed = 1'b1;
			end

		// Queue starts out empty once reset lifts
		aEmptyAfterReset: assert property (@(posedge iClk) $rose(arstN) |-> empty)
			else
			begin
				$error("FIFO not empty after reset");
				assertFailed = 1'b1;
			end
	end
	else
	begin : gRaster
		// ------------------------------
		// Raster range
		// ------------------------------
		// A shrunk frame may leave the position past the end until its next step
		aHposRange: assert property (@(posedge iClk) disable iff (!arstN)
			stepEn |=> (pos <= last) || !$stable(last))
			else
			begin
				$error("hPos beyond hLast after a step");
				assertFailed = 1'b1;
			end

		// Consuming the last position of a frame returns to the top left
		aFrameWrap: assert property (@(posedge iClk) disable iff (!arstN)
			(stepEn && frameEnd) |=> (pos == '0) && (vPos == '0))
			else
			begin
				$error("position not back at the origin after frame end");
				assertFailed = 1'b1;
			end
	end

endmodule

// Every FIFO instance, layer queues and output queue alike
bind pixelFifo videoPixelGenSva #(.pPosWidth(1), .pVposWidth(1), .pFifoSide(1'b1)) fifoChk (
	.iClk     (iClk),
	.arstN    (arstN),
	.wr       (wr),
	.rd       (rd),
	.full     (full),
	.empty    (empty),
	.stepEn   (1'b0),
	.frameEnd (1'b0),
	.pos      (1'b0),
	.vPos     (1'b0),
	.last     (1'b0)
);

// Position counter, FIFO inputs tied idle
bind drawPosition videoPixelGenSva #(
	.pPosWidth  (pHdisplayWidth),
	.pVposWidth (pVdisplayWidth),
	.pFifoSide  (1'b0)
) posChk (
	.iClk     (iClk),
	.arstN    (arstN),
	.wr       (1'b0),
	.rd       (1'b0),
	.full     (1'b0),
	.empty    (1'b1),
	.stepEn   (ras.advance),
	.frameEnd (ras.frameEnd),
	.pos      (ras.hPos),
	.vPos     (ras.vPos),
	.last     (hLast)
);

/* verif/videoPixelGenTb.sv */
// Directed testbench for the raster pixel generator with a scan order reference model
`timescale 1ns/1ps

module videoPixelGenTb;
	import videoPkg::*;

	// Cycles without a beat before giving up
	localparam int cBeatTimeout = 300;
	localparam int cQuietCycles = 40;
	localparam int cDrainLimit = 2000;

	logic iClk;
	logic arstN;
	logic cfgWe;
	cfgAddrT cfgAddr;
	logic [15:0] cfgData;
	logic iCke;
	pixelT oPixel;
	logic oVd;

	// Model position and frame size
	int mH;
	int mV;
	int mHdisp;
	int mVdisp;
	// Model copy of each layer's registers
	int mX0 [cLayers];
	int mX1 [cLayers];
	int mY0 [cLayers];
	int mY1 [cLayers];
	dotT mColor [cLayers];
	logic [31:0] rngState;

	videoPixelGen #(
		.pHdisplayWidth (11),
		.pVdisplayWidth (11),
		.pFifoDepth     (16)
	) dut_i (
		.iClk    (iClk),
		.arstN   (arstN),
		.cfgWe   (cfgWe),
		.cfgAddr (cfgAddr),
		.cfgData (cfgData),
		.iCke    (iCke),
		.oPixel  (oPixel),
		.oVd     (oVd)
	);

	initial
	begin
		iClk = 1'b0;
		forever #10 iClk = ~iClk;
	end

	// ------------------------------
	// Reference model
	// ------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Inclusive rectangle, colour with alpha inside, zero dot outside
	function automatic dotT layerModel(input int idx, input int h, input int v);
		if (h >= mX0[idx] && h <= mX1[idx] && v >= mY0[idx] && v <= mY1[idx])
			return mColor[idx];
		return '0;
	endfunction

	// Player over background, any nonzero alpha is opaque
	function automatic pixelT pixelModel(input int h, input int v);
		dotT bg;
		dotT player;
		bg = layerModel(0, h, v);
		player = layerModel(1, h, v);
		if (player.alpha != 0)
			return player.rgb;
		else if (bg.alpha != 0)
			return bg.rgb;
		return '0;
	endfunction

	// Next position in scan order
	task automatic stepModel();
		if (mH + 1 < mHdisp)
			mH++;
		else
		begin
			mH = 0;
			if (mV + 1 < mVdisp)
				mV++;
			else
				mV = 0;
		end
	endtask

	// ------------------------------
	// Checks
	// ------------------------------
	task automatic abortRun();
		$display("*** FAILED ***");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkPixel(input pixelT got, input pixelT exp, input string name);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkValid(input logic got, input logic exp, input string name);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
			abortRun();
		end
	endtask

	// Sticky flags of every bound checker instance
	function automatic logic assertionFailed();
		return dut_i.uPos.posChk.assertFailed
			|| dut_i.gLayer[0].uLayer.dotFifo.fifoChk.assertFailed
			|| dut_i.gLayer[1].uLayer.dotFifo.fifoChk.assertFailed
			|| dut_i.uMerge.outFifo.fifoChk.assertFailed;
	endfunction

	always @(posedge iClk)
	begin
		if (assertionFailed())
		begin
			$display("A bound assertion failed during the run");
			abortRun();
		end
	end

	// One oVd beat against the model, then step
	task automatic takeBeat();
		checkPixel(oPixel, pixelModel(mH, mV), $sformatf("oPixel at (%0d,%0d)", mH, mV));
		stepModel();
	endtask

	// ------------------------------
	// Bus and sink drivers
	// ------------------------------
	task automatic resetDut();
		arstN = 1'b0;
		repeat (5) @(negedge iClk);
		arstN = 1'b1;
	endtask

	// Sink is held off here, so no beat goes unseen
	task automatic writeReg(input cfgAddrT addr, input logic [15:0] data);
		@(negedge iClk);
		cfgWe = 1'b1;
		cfgAddr = addr;
		cfgData = data;
		@(negedge iClk);
		cfgWe = 1'b0;
		cfgData = '0;
	endtask

	task automatic setSize(input int h, input int v);
		writeReg(cfgHdisp, 16'(h));
		writeReg(cfgVdisp, 16'(v));
		mHdisp = h;
		mVdisp = v;
	endtask

	task automatic setRun(input logic on);
		writeReg(cfgRun, {15'b0, on});
	endtask

	// Five consecutive registers per layer
	task automatic setLayer(input int idx, input int x0, input int x1, input int y0,
		input int y1, input logic [15:0] color);
		cfgAddrT base;
		base = (idx == 0) ? cfgL0X0 : cfgL1X0;
		writeReg(base, 16'(x0));
		writeReg(cfgAddrT'(base + 1), 16'(x1));
		writeReg(cfgAddrT'(base + 2), 16'(y0));
		writeReg(cfgAddrT'(base + 3), 16'(y1));
		writeReg(cfgAddrT'(base + 4), color);
		mX0[idx] = x0;
		mX1[idx] = x1;
		mY0[idx] = y0;
		mY1[idx] = y1;
		mColor[idx] = dotT'(color);
	endtask

	// Sample at the falling edge, then set iCke for the next rising edge
	task automatic expectPixels(input int n, input bit randomCke);
		int got;
		int idle;
		got = 0;
		idle = 0;
		while (got < n)
		begin
			@(negedge iClk);
			if (oVd)
			begin
				takeBeat();
				got++;
				idle = 0;
			end
			else
			begin
				idle++;
				if (idle > cBeatTimeout)
				begin
					$display("Timeout: no pixel on oVd for %0d cycles", cBeatTimeout);
					abortRun();
				end
			end
			if (got < n && randomCke)
			begin
				rngState = xorshift32(rngState);
				// Sink takes about one cycle in four
				iCke = (rngState[1:0] == 2'b00);
			end
			else
				iCke = (got < n);
		end
	endtask

	// Run already low, empty every queue and check what comes out
	task automatic drainOutput();
		int quiet;
		int cycles;
		quiet = 0;
		cycles = 0;
		while (quiet < cQuietCycles)
		begin
			@(negedge iClk);
			if (oVd)
			begin
				takeBeat();
				quiet = 0;
			end
			else
				quiet++;
			cycles++;
			if (cycles > cDrainLimit)
			begin
				$display("Timeout: pipeline still emitting pixels after run was cleared");
				abortRun();
			end
			iCke = (quiet < cQuietCycles);
		end
	endtask

	// ------------------------------
	// Directed tests
	// ------------------------------
	task automatic idleAfterReset();
		repeat (50)
		begin
			@(negedge iClk);
			checkValid(oVd, 1'b0, "oVd");
			iCke = 1'b1;
		end
		iCke = 1'b0;
	endtask

	task automatic fullBackground();
		setSize(8, 4);
		setLayer(0, 0, 7, 0, 3, 16'hF3A5);
		setLayer(1, 0, 7, 0, 3, 16'h0000);
		setRun(1'b1);
		expectPixels(32, 1'b0);
		setRun(1'b0);
		drainOutput();
	endtask

	task automatic overlapLayers();
		setLayer(0, 1, 6, 0, 2, 16'hA0F0);
		setLayer(1, 4, 7, 1, 3, 16'h5ABC);
		setRun(1'b1);
		expectPixels(64, 1'b0);
		setRun(1'b0);
		drainOutput();
	endtask

	// Zero alpha on the player lets the background through
	task automatic transparentPlayer();
		setLayer(0, 0, 3, 1, 2, 16'h8123);
		setLayer(1, 2, 5, 0, 3, 16'h0DEF);
		setRun(1'b1);
		expectPixels(32, 1'b0);
		setRun(1'b0);
		drainOutput();
	endtask

	// Three frames through a stalling sink
	task automatic randomSinkStall();
		setLayer(0, 0, 5, 1, 3, 16'hC456);
		setLayer(1, 3, 7, 0, 2, 16'h7789);
		setRun(1'b1);
		expectPixels(96, 1'b1);
		setRun(1'b0);
		drainOutput();
	endtask

	// Counter may first finish its current line at the new width
	task automatic frameResize();
		setSize(5, 3);
		setRun(1'b1);
		expectPixels(45, 1'b0);
		setRun(1'b0);
		drainOutput();
	endtask

	initial
	begin
		iCke = 1'b0;
		cfgWe = 1'b0;
		cfgAddr = cfgHdisp;
		cfgData = '0;
		arstN = 1'b0;
		rngState = 32'hb034;
		// Reset size registers hold zero, a one dot frame
		mH = 0;
		mV = 0;
		mHdisp = 1;
		mVdisp = 1;
		for (int i = 0; i < cLayers; i++)
		begin
			mX0[i] = 0;
			mX1[i] = 0;
			mY0[i] = 0;
			mY1[i] = 0;
			mColor[i] = '0;
		end
		resetDut();
		idleAfterReset();
		fullBackground();
		overlapLayers();
		transparentPlayer();
		randomSinkStall();
		frameResize();
		if (assertionFailed())
		begin
			$display("A bound assertion failed near the end of the run");
			abortRun();
		end
		else
		begin
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule

/* build.f */
design/videoPkg.sv
design/videoIfs.sv
design/displayCfg.sv
design/drawPosition.sv
design/pixelFifo.sv
design/rectLayer.sv
design/dotMerge.sv
design/videoPixelGen.sv
verif/videoPixelGen_sva.sv
verif/videoPixelGenTb.sv
